// ==== logic/surf_cmd_pkg.sv ====
`default_nettype none

package surf_cmd_pkg;

    // payload widths of the three splice queues
    localparam int RUNCMD_W = 2;
    localparam int TRIG_W   = 15;
    localparam int FW_W     = 8;

    // run command, zero means no command
    typedef logic [RUNCMD_W-1:0] runcmd_t;

    // trigger request, zero means no trigger
    typedef logic [TRIG_W-1:0] trig_t;

    // one firmware-load byte
    typedef logic [FW_W-1:0] fw_t;

    // 32-bit command word as sent to the digitizer boards, msb first
    typedef struct packed {
        // untouched by the splicer
        logic [5:0] reserved;
        // fw_byte carries data only when this is set
        logic       fw_valid;
        fw_t        fw_byte;
        trig_t      trig;
        runcmd_t    runcmd;
    } cmd_word_t;

endpackage

`default_nettype wire

// ==== logic/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

    localparam int WB_ADR_W = 12;
    localparam int WB_DAT_W = 32;

    typedef logic [WB_ADR_W-1:0] wb_adr_t;

    // master to target
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        wb_adr_t             adr;
        logic [3:0]          sel;
        logic [WB_DAT_W-1:0] dat;
    } wb_req_t;

    // target to master, err and rty are not carried
    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] dat;
    } wb_rsp_t;

    // register map, byte addresses
    localparam wb_adr_t ADDR_RUNCMD = 12'h000;
    localparam wb_adr_t ADDR_TRIG   = 12'h004;
    localparam wb_adr_t ADDR_FW     = 12'h008;
    // read only: fw byte count in 31:16, queue full flags in 2:0
    localparam wb_adr_t ADDR_STATUS = 12'h00C;

endpackage

`default_nettype wire

// ==== logic/splice_fifo.sv ====
`default_nettype none

module splice_fifo #(
    parameter int unsigned FIFO_DEPTH = 4,
    parameter type         payload_t  = logic [7:0]
) (
    input  wire logic     sysclk_i,
    input  wire logic     arst_n_i,
    // push side
    input  wire logic     push_valid_i,
    input  wire payload_t push_data_i,
    output logic          push_ready_o,
    // pop side, head entry is always presented
    output logic          pop_valid_o,
    output payload_t      pop_data_o,
    input  wire logic     pop_ready_i
);

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);
    localparam logic [AW-1:0] LAST_IDX = AW'(FIFO_DEPTH - 1);

    payload_t      mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;

    assign push_ready_o = (count != CW'(FIFO_DEPTH));
    assign pop_valid_o  = (count != '0);
    assign pop_data_o   = mem[rd_ptr];

    assign push = push_valid_i & push_ready_o;
    assign pop  = pop_ready_i & pop_valid_o;

    always_ff @(posedge sysclk_i) begin
        if (push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge sysclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + AW'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + AW'(1);
            end
            // simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count <= count + CW'(1);
            end else if (pop && !push) begin
                count <= count - CW'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/splice_register_core.sv ====
`default_nettype none

module splice_register_core (
    input  wire logic                  sysclk_i,
    input  wire logic                  arst_n_i,
    // register bus
    input  wire wb_pkg::wb_req_t       wb_i,
    output wb_pkg::wb_rsp_t            wb_o,
    // run command queue push side
    output logic                       runcmd_valid_o,
    output surf_cmd_pkg::runcmd_t      runcmd_o,
    input  wire logic                  runcmd_ready_i,
    // trigger queue push side
    output logic                       trig_valid_o,
    output surf_cmd_pkg::trig_t        trig_o,
    input  wire logic                  trig_ready_i,
    // firmware byte queue push side
    output logic                       fw_valid_o,
    output surf_cmd_pkg::fw_t          fw_o,
    input  wire logic                  fw_ready_i,
    // firmware bytes sent so far, from the splicer
    input  wire logic [15:0]           fw_sent_i
);

    import wb_pkg::*;
    import surf_cmd_pkg::*;

    logic                ack_q;
    logic [WB_DAT_W-1:0] rd_dat_q;
    logic [WB_DAT_W-1:0] status;
    logic                access;
    logic                wr_runcmd;
    logic                wr_trig;
    logic                wr_fw;
    logic                done;

    // payloads come straight off the write data
    assign runcmd_o = wb_i.dat[RUNCMD_W-1:0];
    assign trig_o   = wb_i.dat[TRIG_W-1:0];
    assign fw_o     = wb_i.dat[FW_W-1:0];

    // full flags are the inverse of the queue ready lines
    assign status = {fw_sent_i, 13'd0, ~fw_ready_i, ~trig_ready_i, ~runcmd_ready_i};

    always_comb begin
        // no new access while ack is up, the master still holds the request then
        access = wb_i.cyc & wb_i.stb & ~ack_q;

        // zero runcmd or trig is acked but never queued
        wr_runcmd = access & wb_i.we & (wb_i.adr == ADDR_RUNCMD) & (runcmd_o != '0);
        wr_trig   = access & wb_i.we & (wb_i.adr == ADDR_TRIG) & (trig_o != '0);
        wr_fw     = access & wb_i.we & (wb_i.adr == ADDR_FW);

        // a push to a full queue stalls the whole transfer
        done = access
             & ~(wr_runcmd & ~runcmd_ready_i)
             & ~(wr_trig & ~trig_ready_i)
             & ~(wr_fw & ~fw_ready_i);
    end

    assign runcmd_valid_o = wr_runcmd;
    assign trig_valid_o   = wr_trig;
    assign fw_valid_o     = wr_fw;

    // one ack per transfer, the cycle after it completes
    always_ff @(posedge sysclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= done;
        end
    end

    // everything but status reads back as zero
    always_ff @(posedge sysclk_i) begin
        if (done) begin
            if (!wb_i.we && wb_i.adr == ADDR_STATUS) begin
                rd_dat_q <= status;
            end else begin
                rd_dat_q <= '0;
            end
        end
    end

    always_comb begin
        wb_o.ack = ack_q;
        wb_o.dat = rd_dat_q;
    end

endmodule

`default_nettype wire

// ==== logic/cmd_splicer.sv ====
`default_nettype none

module cmd_splicer (
    input  wire logic                    sysclk_i,
    input  wire logic                    arst_n_i,
    // command words from the controller
    input  wire surf_cmd_pkg::cmd_word_t command_i,
    input  wire logic                    command_valid_i,
    input  wire logic                    command_locked_i,
    // queue heads
    input  wire logic                    runcmd_valid_i,
    input  wire surf_cmd_pkg::runcmd_t   runcmd_i,
    output logic                         runcmd_ready_o,
    input  wire logic                    trig_valid_i,
    input  wire surf_cmd_pkg::trig_t     trig_i,
    output logic                         trig_ready_o,
    input  wire logic                    fw_valid_i,
    input  wire surf_cmd_pkg::fw_t       fw_i,
    output logic                         fw_ready_o,
    // merged word, one cycle behind command_valid_i
    output surf_cmd_pkg::cmd_word_t      spliced_o,
    output logic                         spliced_valid_o,
    output logic [15:0]                  fw_sent_o
);

    import surf_cmd_pkg::*;

    logic      splice_en;
    logic      fill_runcmd;
    logic      fill_trig;
    logic      fill_fw;
    cmd_word_t merged;
    cmd_word_t spliced_q;
    logic      spliced_valid_q;
    logic [15:0] fw_sent_q;

    // an unlocked link passes words through and pops nothing
    assign splice_en = command_valid_i & command_locked_i;

    // each empty field takes its queue head on its own
    assign fill_runcmd = splice_en & (command_i.runcmd == '0) & runcmd_valid_i;
    assign fill_trig   = splice_en & (command_i.trig == '0) & trig_valid_i;
    assign fill_fw     = splice_en & ~command_i.fw_valid & fw_valid_i;

    // a filled field pops its queue in the same cycle
    assign runcmd_ready_o = fill_runcmd;
    assign trig_ready_o   = fill_trig;
    assign fw_ready_o     = fill_fw;

    always_comb begin
        merged = command_i;
        if (fill_runcmd) begin
            merged.runcmd = runcmd_i;
        end
        if (fill_trig) begin
            merged.trig = trig_i;
        end
        if (fill_fw) begin
            merged.fw_byte  = fw_i;
            merged.fw_valid = 1'b1;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (command_valid_i) begin
            spliced_q <= merged;
        end
    end

    always_ff @(posedge sysclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            spliced_valid_q <= 1'b0;
            fw_sent_q       <= '0;
        end else begin
            spliced_valid_q <= command_valid_i;
            // counter wraps
            if (fill_fw) begin
                fw_sent_q <= fw_sent_q + 16'd1;
            end
        end
    end

    assign spliced_o       = spliced_q;
    assign spliced_valid_o = spliced_valid_q;
    assign fw_sent_o       = fw_sent_q;

endmodule

`default_nettype wire

// ==== logic/surfturf_bridge.sv ====
`default_nettype none

module surfturf_bridge #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  wire logic                    sysclk_i,
    input  wire logic                    arst_n_i,
    input  wire wb_pkg::wb_req_t         wb_i,
    output wb_pkg::wb_rsp_t              wb_o,
    input  wire surf_cmd_pkg::cmd_word_t command_i,
    input  wire logic                    command_valid_i,
    input  wire logic                    command_locked_i,
    output surf_cmd_pkg::cmd_word_t      spliced_o,
    output logic                         spliced_valid_o
);

    import surf_cmd_pkg::*;

    // push side, core to queues
    logic    runcmd_push_valid;
    runcmd_t runcmd_push_data;
    logic    runcmd_push_ready;
    logic    trig_push_valid;
    trig_t   trig_push_data;
    logic    trig_push_ready;
    logic    fw_push_valid;
    fw_t     fw_push_data;
    logic    fw_push_ready;

    // pop side, queues to splicer
    logic    runcmd_pop_valid;
    runcmd_t runcmd_pop_data;
    logic    runcmd_pop_ready;
    logic    trig_pop_valid;
    trig_t   trig_pop_data;
    logic    trig_pop_ready;
    logic    fw_pop_valid;
    fw_t     fw_pop_data;
    logic    fw_pop_ready;

    logic [15:0] fw_sent;

    splice_register_core u_core (
        .sysclk_i       (sysclk_i),
        .arst_n_i       (arst_n_i),
        .wb_i           (wb_i),
        .wb_o           (wb_o),
        .runcmd_valid_o (runcmd_push_valid),
        .runcmd_o       (runcmd_push_data),
        .runcmd_ready_i (runcmd_push_ready),
        .trig_valid_o   (trig_push_valid),
        .trig_o         (trig_push_data),
        .trig_ready_i   (trig_push_ready),
        .fw_valid_o     (fw_push_valid),
        .fw_o           (fw_push_data),
        .fw_ready_i     (fw_push_ready),
        .fw_sent_i      (fw_sent)
    );

    splice_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .payload_t  (runcmd_t)
    ) u_runcmd_q (
        .sysclk_i     (sysclk_i),
        .arst_n_i     (arst_n_i),
        .push_valid_i (runcmd_push_valid),
        .push_data_i  (runcmd_push_data),
        .push_ready_o (runcmd_push_ready),
        .pop_valid_o  (runcmd_pop_valid),
        .pop_data_o   (runcmd_pop_data),
        .pop_ready_i  (runcmd_pop_ready)
    );

    splice_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .payload_t  (trig_t)
    ) u_trig_q (
        .sysclk_i     (sysclk_i),
        .arst_n_i     (arst_n_i),
        .push_valid_i (trig_push_valid),
        .push_data_i  (trig_push_data),
        .push_ready_o (trig_push_ready),
        .pop_valid_o  (trig_pop_valid),
        .pop_data_o   (trig_pop_data),
        .pop_ready_i  (trig_pop_ready)
    );

    splice_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .payload_t  (fw_t)
    ) u_fw_q (
        .sysclk_i     (sysclk_i),
        .arst_n_i     (arst_n_i),
        .push_valid_i (fw_push_valid),
        .push_data_i  (fw_push_data),
        .push_ready_o (fw_push_ready),
        .pop_valid_o  (fw_pop_valid),
        .pop_data_o   (fw_pop_data),
        .pop_ready_i  (fw_pop_ready)
    );

    cmd_splicer u_splicer (
        .sysclk_i         (sysclk_i),
        .arst_n_i         (arst_n_i),
        .command_i        (command_i),
        .command_valid_i  (command_valid_i),
        .command_locked_i (command_locked_i),
        .runcmd_valid_i   (runcmd_pop_valid),
        .runcmd_i         (runcmd_pop_data),
        .runcmd_ready_o   (runcmd_pop_ready),
        .trig_valid_i     (trig_pop_valid),
        .trig_i           (trig_pop_data),
        .trig_ready_o     (trig_pop_ready),
        .fw_valid_i       (fw_pop_valid),
        .fw_i             (fw_pop_data),
        .fw_ready_o       (fw_pop_ready),
        .spliced_o        (spliced_o),
        .spliced_valid_o  (spliced_valid_o),
        .fw_sent_o        (fw_sent)
    );

endmodule

`default_nettype wire

// ==== test/tb_surfturf_bridge.sv ====
`default_nettype none

module tb_surfturf_bridge;

    import wb_pkg::*;
    import surf_cmd_pkg::*;

    localparam int unsigned FIFO_DEPTH     = 4;
    localparam int          TIMEOUT_CYCLES = 50;
    // cycles a write to a full queue must stay unacked
    localparam int          HOLD_CYCLES    = 8;
    localparam int unsigned SEED           = 32'h3abd_772e;
    localparam string       DATA_FILE      = "test/surfturf_testdata.txt";

    logic      sysclk = 1'b0;
    logic      arst_n;
    wb_req_t   wb_req;
    wb_rsp_t   wb_rsp;
    cmd_word_t command;
    logic      command_valid;
    logic      command_locked;
    cmd_word_t spliced;
    logic      spliced_valid;

    int error_count   = 0;
    int timeout_count = 0;

    always #5 sysclk = ~sysclk;

    surfturf_bridge #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_surfturf_bridge (
        .sysclk_i         (sysclk),
        .arst_n_i         (arst_n),
        .wb_i             (wb_req),
        .wb_o             (wb_rsp),
        .command_i        (command),
        .command_valid_i  (command_valid),
        .command_locked_i (command_locked),
        .spliced_o        (spliced),
        .spliced_valid_o  (spliced_valid)
    );

    task automatic check_cmd(input cmd_word_t got, input cmd_word_t exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_rsp(input wb_rsp_t got, input logic [WB_DAT_W-1:0] exp,
                             input string what);
        if (got.dat !== exp) begin
            error_count++;
            $display("error at %0t: %s got %h expected %h", $time, what, got.dat, exp);
        end
    endtask

    function automatic wb_req_t make_req(input logic we, input wb_adr_t adr,
                                         input logic [WB_DAT_W-1:0] dat);
        wb_req_t req;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = adr;
        req.sel = 4'hf;
        req.dat = dat;
        return req;
    endfunction

    // polls ack at the falling edge, where it is stable
    task automatic wait_ack(output logic seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            @(negedge sysclk);
            seen = wb_rsp.ack;
            cycles++;
        end
        if (!seen) begin
            timeout_count++;
            $display("timeout at %0t: the register bus never acknowledged", $time);
        end
    endtask

    task automatic bus_write(input wb_adr_t adr, input logic [WB_DAT_W-1:0] dat);
        logic seen;
        @(posedge sysclk);
        wb_req <= make_req(1'b1, adr, dat);
        wait_ack(seen);
        @(posedge sysclk);
        wb_req <= '0;
    endtask

    task automatic bus_read(input wb_adr_t adr, input logic [WB_DAT_W-1:0] exp);
        logic seen;
        @(posedge sysclk);
        wb_req <= make_req(1'b0, adr, '0);
        wait_ack(seen);
        if (seen) begin
            check_rsp(wb_rsp, exp, $sformatf("read of 0x%03h", adr));
        end
        @(posedge sysclk);
        wb_req <= '0;
    endtask

    task automatic send_cmd(input cmd_word_t cmd, input logic locked, input cmd_word_t exp);
        int   gap;
        int   cycles;
        logic seen;
        // random idle time between command words
        gap = $urandom_range(3, 0);
        repeat (gap) @(posedge sysclk);
        @(posedge sysclk);
        command        <= cmd;
        command_locked <= locked;
        command_valid  <= 1'b1;
        @(posedge sysclk);
        command_valid  <= 1'b0;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            @(negedge sysclk);
            seen = spliced_valid;
            cycles++;
        end
        if (seen) begin
            // the merged word is due one cycle after the command
            if (cycles != 1) begin
                error_count++;
                $display("error at %0t: spliced word for %h took %0d cycles, expected 1",
                         $time, cmd, cycles);
            end
            check_cmd(spliced, exp, $sformatf("spliced word for %h", cmd));
        end else begin
            timeout_count++;
            $display("timeout at %0t: no spliced word came out for command %h", $time, cmd);
        end
    endtask

    // write into a full queue that only the command can release
    task automatic held_write(input wb_adr_t adr, input logic [WB_DAT_W-1:0] dat,
                              input cmd_word_t cmd, input logic locked,
                              input cmd_word_t exp);
        int   cycles;
        logic early;
        logic seen;
        @(posedge sysclk);
        wb_req <= make_req(1'b1, adr, dat);
        early = 1'b0;
        cycles = 0;
        while (!early && cycles < HOLD_CYCLES) begin
            @(negedge sysclk);
            early = wb_rsp.ack;
            cycles++;
        end
        if (early) begin
            error_count++;
            $display("error at %0t: write to a full queue acked before any command", $time);
        end else begin
            send_cmd(cmd, locked, exp);
            wait_ack(seen);
        end
        @(posedge sysclk);
        wb_req <= '0;
    endtask

    initial begin
        int          fd;
        string       line;
        logic [7:0]  op;
        logic [31:0] fld [5];
        void'($urandom(SEED));
        arst_n         = 1'b0;
        wb_req         = '0;
        command        = '0;
        command_valid  = 1'b0;
        command_locked = 1'b0;
        repeat (5) @(posedge sysclk);
        arst_n <= 1'b1;

        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            error_count++;
            $display("could not open the data file %s", DATA_FILE);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // blank lines and comment lines carry no op
                if (line.len() > 1 && line.getc(0) != "#") begin
                    op = line.getc(0);
                    foreach (fld[i]) fld[i] = '0;
                    void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
                                  fld[0], fld[1], fld[2], fld[3], fld[4]));
                    case (op)
                        "W": bus_write(fld[0][11:0], fld[1]);
                        "R": bus_read(fld[0][11:0], fld[1]);
                        "C": send_cmd(fld[0], fld[1][0], fld[2]);
                        "P": held_write(fld[0][11:0], fld[1], fld[2], fld[3][0], fld[4]);
                        default: begin
                            error_count++;
                            $display("unknown op in data file line: %s", line);
                        end
                    endcase
                end
            end
            $fclose(fd);
        end

        repeat (3) @(posedge sysclk);
        $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/surfturf_testdata.txt ====
# W adr data, bus write | R adr expected, bus read
# C cmd locked expected | P adr data cmd locked expected, write held until cmd drains the queue
# zero runcmd and trig are acked but queue nothing
W 000 00000000
W 004 00000000
# one item in each queue, all land in one word, reserved bits kept
W 000 00000002
W 004 00001234
W 008 000000a5
C a8000000 1 ab4a48d2
# trig already set passes, queued trig waits for the next word
W 004 00000055
C 00000401 1 00000401
C 04000000 1 04000154
# unlocked words pass through and pop nothing
W 000 00000003
W 008 0000003c
C 00000000 0 00000000
C fc000000 0 fc000000
C 00000000 1 02780003
# unmapped addresses
W 020 deadbeef
R 010 00000000
R 00c 00020000
# fill the fw queue, the fifth write waits for a command
W 008 00000011
W 008 00000022
W 008 00000033
W 008 00000044
R 00c 00020004
P 008 00000055 00000000 1 02220000
R 00c 00030004
# fw_valid already set, no byte popped
C 02000000 1 02000000
C 00000000 1 02440000
C 00000000 1 02660000
C 00000000 1 02880000
C 00000000 1 02aa0000
R 00c 00070000

// ==== verilog.f ====
logic/surf_cmd_pkg.sv
logic/wb_pkg.sv
logic/splice_fifo.sv
logic/splice_register_core.sv
logic/cmd_splicer.sv
logic/surfturf_bridge.sv
test/tb_surfturf_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    -f verilog.f --top-module tb_surfturf_bridge \
    -Mdir "$BUILD_DIR" -o sim_surfturf
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"./$BUILD_DIR/sim_surfturf" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -F '*** FAILED ***' "$LOG"; then
    exit 1
fi
exit 0
